// File: bench/dns_filter_stim.txt
// tag last keep data: tag 1 rx beat, 2 expected bypass tx beat, 4 expected udp tx beat, 3 db flag
// data byte 0 is the first byte on the wire, flags are answered in lookup order
10ffa1a1a1a1a1a1a1a1
10ff1111dd8611111111
10ff2222222222222222
10ff3333333333333333
113f4444444444444444
10ffa2a2a2a2a2a2a2a2
110f00450008cc020304
10ffa3a3a3a3a3a3a3a3
10ff00450008cc030303
10ff1140000000340000
10ffa8c00a00000a0000
113f0010350034120a01
10ffa4a4a4a4a4a4a4a4
10ff00450008cc040404
10ff1140000000480000
10ffa8c0080808080000
113f001050c335000a01
10ffa5a5a5a5a5a5a5a5
10ff00450008cc050505
10ff1140000000520000
10ffa8c0040302010000
113f0010901f35000a01
10ffa6a6a6a6a6a6a6a6
10ff00450008cc060606
10ff1140000000290000
10ffa8c0140000140000
113f0010881350000a01
30000000000000000000
30000000000000000001
20ffa1a1a1a1a1a1a1a1
20ff1111dd8611111111
20ff2222222222222222
20ff3333333333333333
213f4444444444444444
20ffa2a2a2a2a2a2a2a2
210f00450008cc020304
40ffa3a3a3a3a3a3a3a3
40ff00450008cc030303
40ff1140000000340000
40ffa8c00a00000a0000
413f0010350034120a01
40ffa4a4a4a4a4a4a4a4
40ff00450008cc040404
40ff1140000000480000
40ffa8c0080808080000
413f001050c335000a01
40ffa6a6a6a6a6a6a6a6
40ff00450008cc060606
40ff1140000000290000
40ffa8c0140000140000
413f0010881350000a01

// File: bench/tb_dns_filter.sv
// frames are sent back to back with no idle gap; tx frames are matched by their first data word
`timescale 1ns/1ps
`include "dns_filter_params.svh"

module tb_dns_filter;

	logic               clk156 = 1'b0;
	logic               rst = 1'b1;
	logic               rx_valid = 1'b0;
	logic [`DATA_W-1:0] rx_data = '0;
	logic [`KEEP_W-1:0] rx_keep = '0;
	logic               rx_last = 1'b0;
	logic               tx_ready = 1'b0;
	logic               lookup_ack = 1'b0;
	logic [3:0]         lookup_flag = 4'd0;
	logic               tx_valid, tx_last, lookup_req;
	logic [`DATA_W-1:0] tx_data;
	logic [`KEEP_W-1:0] tx_keep;
	logic [`KEY_W-1:0]  lookup_key;

	logic [79:0]       stim [0:255];  // tag, last, keep, data
	logic [79:0]       rx_q[$], byp_q[$], udp_q[$];
	logic [3:0]        flag_q[$];
	logic [`KEY_W-1:0] key_q[$];
	integer            seed = 32'h164b_e28a;
	int                errors = 0, tests = 0, bad_tests = 0;
	int                cycles = 0, limit = 0, lookups = 0, frame_no = 0, frame_base = 0;
	int                db_wait = 0, tx_path = 0, lookup_base = 0;
	logic              db_busy = 1'b0, in_tx = 1'b0, stall_prev = 1'b0;
	logic              req_prev = 1'b0, ack_prev = 1'b0;
	logic [79:0]       exp_beat;
	logic [`DATA_W-1:0] held_data;

	dns_filter_top UUT (
		.clk156, .rst, .rx_valid, .rx_data, .rx_keep, .rx_last,
		.tx_valid, .tx_data, .tx_keep, .tx_last, .tx_ready,
		.lookup_req, .lookup_key, .lookup_ack, .lookup_flag
	);

	always #20 clk156 = ~clk156;

	function automatic logic [7:0] byte_at(input logic [63:0] d, input int k);
		return d[8*k +: 8];
	endfunction

	// network order fields from frame bytes 26..37
	function automatic logic [`KEY_W-1:0] build_key(input logic [63:0] b3, input logic [63:0] b4);
		return {byte_at(b3, 2), byte_at(b3, 3), byte_at(b3, 4), byte_at(b3, 5),
		        byte_at(b3, 6), byte_at(b3, 7), byte_at(b4, 0), byte_at(b4, 1),
		        byte_at(b4, 4), byte_at(b4, 5), byte_at(b4, 2), byte_at(b4, 3)};
	endfunction

	task automatic check_value(input string name, input logic [95:0] expected,
	                           input logic [95:0] actual);
		if (expected !== actual) begin
			$display("Fail %s expected %h actual %h", name, expected, actual);
			errors++;
		end
	endtask

	task automatic report_test(input string name, input int err_before);
		tests++;
		if (errors == err_before)
			$display("test %s: ok", name);
		else begin
			bad_tests++;
			$display("test %s: mismatch", name);
		end
	endtask

	always @(posedge clk156) begin
		cycles++;
		if (limit > 0 && cycles > limit) begin
			$display("timeout: run did not finish within %0d cycles", limit);
			$display("tests failed");
			$finish;
		end
	end

	always @(posedge clk156)
		tx_ready <= ($random(seed) & 3) != 0;  // about one stall in four

	// flow database, answers after a random delay
	always @(posedge clk156) begin
		if (rst) begin
			lookup_ack <= 1'b0;
			db_busy = 1'b0;
		end else if (lookup_req && !lookup_ack) begin
			if (!db_busy) begin
				db_busy = 1'b1;
				db_wait = $random(seed) & 7;
			end else if (db_wait > 0)
				db_wait--;
			else begin
				db_busy = 1'b0;
				lookups++;
				lookup_base = errors;
				if (key_q.size() == 0) begin
					$display("error: lookup_req raised for a frame that needs no lookup");
					errors++;
				end else
					check_value($sformatf("lookup_%0d_key", lookups), key_q.pop_front(),
					            lookup_key);
				if (flag_q.size() == 0)
					lookup_flag <= 4'd0;
				else
					lookup_flag <= flag_q.pop_front();
				lookup_ack <= 1'b1;
				report_test($sformatf("lookup_%0d", lookups), lookup_base);
			end
		end else if (lookup_ack && !lookup_req)
			lookup_ack <= 1'b0;
	end

	// four-phase rules
	always @(posedge clk156) begin
		if (!rst) begin
			if (req_prev && !ack_prev && !lookup_req) begin
				$display("error: lookup_req fell before lookup_ack rose");
				errors++;
			end
			if (!req_prev && lookup_req && ack_prev) begin
				$display("error: lookup_req rose while lookup_ack was still high");
				errors++;
			end
		end
		req_prev <= lookup_req;
		ack_prev <= lookup_ack;
	end

	always @(posedge clk156) begin
		if (!rst && stall_prev && (!tx_valid || tx_data !== held_data)) begin
			$display("error: transmit beat changed while tx_ready was low");
			errors++;
		end
		stall_prev = !rst && tx_valid && !tx_ready;
		held_data  = tx_data;
		if (!rst && tx_valid && tx_ready) begin
			if (!in_tx) begin
				in_tx = 1'b1;
				frame_base = errors;
				if (byp_q.size() > 0 && byp_q[0][63:0] === tx_data)
					tx_path = 0;
				else if (udp_q.size() > 0 && udp_q[0][63:0] === tx_data)
					tx_path = 1;
				else begin
					tx_path = 2;
					$display("error: frame on transmit starting %h matches no expected frame",
					         tx_data);
					errors++;
				end
			end
			if ((tx_path == 0 && byp_q.size() == 0) || (tx_path == 1 && udp_q.size() == 0)) begin
				$display("error: transmit frame is longer than expected");
				errors++;
			end else if (tx_path != 2) begin
				exp_beat = (tx_path == 0) ? byp_q.pop_front() : udp_q.pop_front();
				check_value($sformatf("tx_frame_%0d_data", frame_no + 1), exp_beat[63:0], tx_data);
				check_value($sformatf("tx_frame_%0d_keep", frame_no + 1), exp_beat[71:64], tx_keep);
				check_value($sformatf("tx_frame_%0d_last", frame_no + 1), exp_beat[72], tx_last);
			end
			if (tx_last) begin
				in_tx = 1'b0;
				frame_no++;
				report_test($sformatf("tx_frame_%0d", frame_no), frame_base);
			end
		end
	end

	initial begin
		logic [79:0] rec;
		logic [63:0] b3;
		logic [15:0] ftype;
		logic [7:0]  proto;
		int          bi;
		int          base;

		for (int i = 0; i < 256; i++)
			stim[i] = '0;
		$readmemh("bench/dns_filter_stim.txt", stim);
		bi = 0;
		for (int i = 0; i < 256 && stim[i][79:76] != 4'h0; i++) begin
			rec = stim[i];
			case (rec[79:76])
				4'h1: begin
					rx_q.push_back(rec);
					if (bi == 1)
						ftype = {byte_at(rec[63:0], 4), byte_at(rec[63:0], 5)};
					if (bi == 2)
						proto = byte_at(rec[63:0], 7);
					if (bi == 3)
						b3 = rec[63:0];
					if (bi == 4 && ftype == `ETH_FTYPE_IP && proto == `IP_PROTO_UDP &&
					    {byte_at(rec[63:0], 2), byte_at(rec[63:0], 3)} == `DNS_PORT)
						key_q.push_back(build_key(b3, rec[63:0]));
					bi = rec[72] ? 0 : bi + 1;
				end
				4'h2: byp_q.push_back(rec);
				4'h3: flag_q.push_back(rec[3:0]);
				4'h4: udp_q.push_back(rec);
				default: ;
			endcase
		end
		limit = (rx_q.size() + byp_q.size() + udp_q.size()) * 16 + 500;

		repeat (2) @(posedge clk156);
		rst <= 1'b0;
		@(posedge clk156);
		base = errors;
		check_value("reset_tx_valid", 0, tx_valid);
		check_value("reset_lookup_req", 0, lookup_req);
		report_test("reset", base);

		foreach (rx_q[i]) begin
			rx_valid <= 1'b1;
			rx_data  <= rx_q[i][63:0];
			rx_keep  <= rx_q[i][71:64];
			rx_last  <= rx_q[i][72];
			@(posedge clk156);
		end
		rx_valid <= 1'b0;
		rx_last  <= 1'b0;

		while (byp_q.size() > 0 || udp_q.size() > 0 || in_tx || lookup_req || lookup_ack)
			@(posedge clk156);
		repeat (2 * `STEER_DEPTH) @(posedge clk156);  // window for stray frames
		base = errors;
		if (key_q.size() != 0 || flag_q.size() != 0) begin
			$display("error: %0d expected lookups never happened", key_q.size());
			errors++;
		end
		report_test("drain", base);

		$display("%0d tests run, %0d ok, %0d with errors, %0d errors", tests,
		         tests - bad_tests, bad_tests, errors);
		if (errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

// File: dns_filter.f
+incdir+verilog
verilog/dns_filter_pkg.sv
verilog/stream_fifo.sv
verilog/rx_header_parser.sv
verilog/frame_steer.sv
verilog/lookup_client.sv
verilog/verdict_gate.sv
verilog/tx_merge.sv
verilog/dns_filter_top.sv
bench/tb_dns_filter.sv

// File: run_sim.sh
#!/bin/sh
# run from the project root
verilator --binary --timing --assert -Wno-fatal -f dns_filter.f \
	--top-module tb_dns_filter -o sim_dns_filter || { echo "compile error"; exit 1; }
./obj_dir/sim_dns_filter > sim.log 2>&1 || { cat sim.log; echo "simulation error"; exit 1; }
cat sim.log
grep -q "tests failed" sim.log && { echo "FAIL"; exit 1; }
grep -q "all tests passed" sim.log || { echo "no verdict in log"; exit 1; }
echo "PASS"
exit 0

// File: verilog/dns_filter_params.svh
// receive cannot be stalled so every depth here must cover the worst burst the link can deliver
`ifndef DNS_FILTER_PARAMS_SVH
`define DNS_FILTER_PARAMS_SVH

`define DATA_W 64
`define KEEP_W 8
`define KEY_W 96

`define STEER_DEPTH 12  // must stay above 5 so the class is known in time
`define HOLD_DEPTH 256
`define BYPASS_DEPTH 64
`define QUEUE_DEPTH 16  // frames, not beats

`define ETH_FTYPE_IP 16'h0800
`define IP_PROTO_UDP 8'h11
`define DNS_PORT 16'd53

// database flag value for drop
`define FLAG_DROP 4'd1

`endif

// File: verilog/dns_filter_pkg.sv
// payload types assume the 64-bit beat layout that the parser offsets are written for
package dns_filter_pkg;

`include "dns_filter_params.svh"

	// one stream beat, 73 bits
	typedef struct packed {
		logic [`DATA_W-1:0] data;
		logic [`KEEP_W-1:0] keep;
		logic               last;
	} beat_t;

	// key is src ip, dst ip, dst port, src port
	typedef struct packed {
		logic              needs_lookup;
		logic [`KEY_W-1:0] key;
	} lookup_entry_t;

	typedef struct packed {
		logic drop;
	} verdict_t;

endpackage

// File: verilog/dns_filter_top.sv
// receive has no ready so the FIFO depths bound how long transmit may stall
`timescale 1ns/1ps
`include "dns_filter_params.svh"

module dns_filter_top import dns_filter_pkg::*; (
	input  logic               clk156,
	input  logic               rst,
	input  logic               rx_valid,
	input  logic [`DATA_W-1:0] rx_data,
	input  logic [`KEEP_W-1:0] rx_keep,
	input  logic               rx_last,
	output logic               tx_valid,
	output logic [`DATA_W-1:0] tx_data,
	output logic [`KEEP_W-1:0] tx_keep,
	output logic               tx_last,
	input  logic               tx_ready,
	output logic               lookup_req,
	output logic [`KEY_W-1:0]  lookup_key,
	input  logic               lookup_ack,
	input  logic [3:0]         lookup_flag
);

	logic          class_valid, class_udp;
	logic          entry_push, entry_pop, entry_empty;
	lookup_entry_t parsed_entry, queued_entry;
	logic          hold_push, hold_pop, hold_empty;
	logic          bypass_push, bypass_pop, bypass_empty;
	beat_t         steer_beat, hold_beat, bypass_beat, pass_beat;
	logic          verdict_push, verdict_pop, verdict_empty;
	verdict_t      new_verdict, head_verdict;
	logic          pass_valid, pass_ready;

	rx_header_parser u_parser (
		.clk156, .rst, .rx_valid, .rx_data, .rx_keep, .rx_last,
		.class_valid, .class_udp, .entry_push, .entry(parsed_entry)
	);

	frame_steer u_steer (
		.clk156, .rst, .rx_valid, .rx_data, .rx_keep, .rx_last,
		.class_valid, .class_udp, .hold_push, .bypass_push, .beat(steer_beat)
	);

	// udp frames wait here for their verdict
	stream_fifo #(.payload_t(beat_t), .depth(`HOLD_DEPTH)) u_hold_fifo (
		.clk156, .rst, .push(hold_push), .push_data(steer_beat), .full(),
		.pop(hold_pop), .empty(hold_empty), .pop_data(hold_beat)
	);

	stream_fifo #(.payload_t(beat_t), .depth(`BYPASS_DEPTH)) u_bypass_fifo (
		.clk156, .rst, .push(bypass_push), .push_data(steer_beat), .full(),
		.pop(bypass_pop), .empty(bypass_empty), .pop_data(bypass_beat)
	);

	stream_fifo #(.payload_t(lookup_entry_t), .depth(`QUEUE_DEPTH)) u_entry_fifo (
		.clk156, .rst, .push(entry_push), .push_data(parsed_entry), .full(),
		.pop(entry_pop), .empty(entry_empty), .pop_data(queued_entry)
	);

	stream_fifo #(.payload_t(verdict_t), .depth(`QUEUE_DEPTH)) u_verdict_fifo (
		.clk156, .rst, .push(verdict_push), .push_data(new_verdict), .full(),
		.pop(verdict_pop), .empty(verdict_empty), .pop_data(head_verdict)
	);

	lookup_client u_lookup (
		.clk156, .rst, .entry_empty, .entry(queued_entry), .entry_pop,
		.lookup_req, .lookup_key, .lookup_ack, .lookup_flag,
		.verdict_push, .verdict(new_verdict)
	);

	verdict_gate u_gate (
		.clk156, .rst, .hold_empty, .hold_beat, .hold_pop,
		.verdict_empty, .verdict(head_verdict), .verdict_pop,
		.pass_valid, .pass_beat, .pass_ready
	);

	tx_merge u_merge (
		.clk156, .rst, .bypass_empty, .bypass_beat, .bypass_pop,
		.pass_valid, .pass_beat, .pass_ready,
		.tx_valid, .tx_data, .tx_keep, .tx_last, .tx_ready
	);

endmodule

// File: verilog/frame_steer.sv
// assumes the header beats arrive close enough that each class is known before its frame leaves
`timescale 1ns/1ps
`include "dns_filter_params.svh"

module frame_steer import dns_filter_pkg::*; (
	input  logic               clk156,
	input  logic               rst,
	input  logic               rx_valid,
	input  logic [`DATA_W-1:0] rx_data,
	input  logic [`KEEP_W-1:0] rx_keep,
	input  logic               rx_last,
	input  logic               class_valid,
	input  logic               class_udp,
	output logic               hold_push,
	output logic               bypass_push,
	output beat_t              beat
);

	localparam int D = `STEER_DEPTH;

	logic [D-1:0] line_vld;
	beat_t        line_beat [D];
	logic [15:0]  cls_q;  // one bit per frame still in the line
	logic [4:0]   cls_wr, cls_rd;
	logic         sof, cur_udp, out_vld, udp_now;

	assign out_vld     = line_vld[D-1];
	assign beat        = line_beat[D-1];
	assign udp_now     = sof ? cls_q[cls_rd[3:0]] : cur_udp;
	assign hold_push   = out_vld && udp_now;
	assign bypass_push = out_vld && !udp_now;

	always_ff @(posedge clk156) begin
		line_beat[0] <= '{data: rx_data, keep: rx_keep, last: rx_last};
		for (int i = 1; i < D; i++)
			line_beat[i] <= line_beat[i-1];
		if (class_valid)
			cls_q[cls_wr[3:0]] <= class_udp;
		if (out_vld && sof)
			cur_udp <= cls_q[cls_rd[3:0]];  // held for the rest of the frame
	end

	always_ff @(posedge clk156) begin
		if (rst) begin
			line_vld <= '0;
			cls_wr   <= '0;
			cls_rd   <= '0;
			sof      <= 1'b1;
		end else begin
			line_vld <= {line_vld[D-2:0], rx_valid};
			if (class_valid)
				cls_wr <= cls_wr + 1'b1;
			if (out_vld && sof)
				cls_rd <= cls_rd + 1'b1;
			if (out_vld)
				sof <= beat.last;
		end
	end

	a_class_ready: assert property (@(posedge clk156) disable iff (rst)
		out_vld && sof |-> cls_wr != cls_rd)
		else $error("frame_steer frame left the delay line before its class");

endmodule

// File: verilog/lookup_client.sv
// one lookup in flight at a time so verdicts leave in frame order
`timescale 1ns/1ps
`include "dns_filter_params.svh"

module lookup_client import dns_filter_pkg::*; (
	input  logic              clk156,
	input  logic              rst,
	input  logic              entry_empty,
	input  lookup_entry_t     entry,
	output logic              entry_pop,
	output logic              lookup_req,
	output logic [`KEY_W-1:0] lookup_key,
	input  logic              lookup_ack,
	input  logic [3:0]        lookup_flag,
	output logic              verdict_push,
	output verdict_t          verdict
);

	typedef enum logic [1:0] {st_idle, st_req, st_release} state_t;
	state_t state;

	assign entry_pop = state == st_idle && !entry_empty;

	always_ff @(posedge clk156) begin
		if (entry_pop) begin
			lookup_key   <= entry.key;
			verdict.drop <= 1'b0;  // plain udp passes
		end else if (state == st_req && lookup_ack)
			verdict.drop <= lookup_flag == `FLAG_DROP;
	end

	always_ff @(posedge clk156) begin
		if (rst) begin
			state        <= st_idle;
			lookup_req   <= 1'b0;
			verdict_push <= 1'b0;
		end else begin
			verdict_push <= 1'b0;
			case (state)
				st_idle: if (!entry_empty) begin
					if (entry.needs_lookup) begin
						lookup_req <= 1'b1;
						state      <= st_req;
					end else
						verdict_push <= 1'b1;
				end
				st_req: if (lookup_ack) begin
					lookup_req   <= 1'b0;
					verdict_push <= 1'b1;
					state        <= st_release;
				end
				st_release: if (!lookup_ack) state <= st_idle;  // wait for ack low
				default: state <= st_idle;
			endcase
		end
	end

	a_req_rise: assert property (@(posedge clk156) disable iff (rst)
		$rose(lookup_req) |-> !lookup_ack)
		else $error("lookup_client raised req while ack was still high");

endmodule

// File: verilog/rx_header_parser.sv
// fixed offsets assume untagged Ethernet and a 20-byte IPv4 header with no options
`timescale 1ns/1ps
`include "dns_filter_params.svh"

module rx_header_parser import dns_filter_pkg::*; (
	input  logic                clk156,
	input  logic                rst,
	input  logic                rx_valid,
	input  logic [`DATA_W-1:0]  rx_data,
	input  logic [`KEEP_W-1:0]  rx_keep,
	input  logic                rx_last,
	output logic                class_valid,
	output logic                class_udp,
	output logic                entry_push,
	output lookup_entry_t       entry
);

	logic [2:0]  beat_cnt;  // saturates at 5
	logic [15:0] ftype;
	logic [7:0]  proto;
	logic [31:0] src_ip;
	logic [15:0] dst_ip_hi;
	logic [15:0] dst_ip_lo, src_port, dst_port;
	logic        hdr_end, short_end, is_udp;
	logic [7:0]  frame_cnt, pulse_cnt;

	// beat 4 fields, taken straight off the bus
	assign dst_ip_lo = {rx_data[7:0], rx_data[15:8]};
	assign src_port  = {rx_data[23:16], rx_data[31:24]};
	assign dst_port  = {rx_data[39:32], rx_data[47:40]};

	assign hdr_end   = rx_valid && beat_cnt == 3'd4;
	assign short_end = rx_valid && rx_last && beat_cnt < 3'd4;
	assign is_udp    = ftype == `ETH_FTYPE_IP && proto == `IP_PROTO_UDP;

	// keep is not needed for the header, only the beat count matters
	always_ff @(posedge clk156) begin
		if (rx_valid) begin
			case (beat_cnt)
				3'd1: ftype <= {rx_data[39:32], rx_data[47:40]};
				3'd2: proto <= rx_data[63:56];
				3'd3: begin
					src_ip    <= {rx_data[23:16], rx_data[31:24],
					              rx_data[39:32], rx_data[47:40]};
					dst_ip_hi <= {rx_data[55:48], rx_data[63:56]};
				end
				default: ;
			endcase
		end
		if (hdr_end) begin
			entry.needs_lookup <= src_port == `DNS_PORT;
			entry.key          <= {src_ip, dst_ip_hi, dst_ip_lo, dst_port, src_port};
		end
	end

	always_ff @(posedge clk156) begin
		if (rst) begin
			beat_cnt    <= '0;
			class_valid <= 1'b0;
			class_udp   <= 1'b0;
			entry_push  <= 1'b0;
		end else begin
			if (rx_valid) begin
				if (rx_last)
					beat_cnt <= '0;
				else if (beat_cnt != 3'd5)
					beat_cnt <= beat_cnt + 1'b1;
			end
			class_valid <= hdr_end || short_end;
			class_udp   <= hdr_end && is_udp;
			entry_push  <= hdr_end && is_udp;  // one entry per udp frame
		end
	end

	// frames seen vs class pulses given
	always_ff @(posedge clk156) begin
		if (rst) begin
			frame_cnt <= '0;
			pulse_cnt <= '0;
		end else begin
			if (rx_valid && rx_last)
				frame_cnt <= frame_cnt + 1'b1;
			if (class_valid)
				pulse_cnt <= pulse_cnt + 1'b1;
		end
	end

	a_one_class_per_frame: assert property (@(posedge clk156) disable iff (rst)
		rx_valid && rx_last |=> frame_cnt == pulse_cnt + {7'd0, class_valid})
		else $error("rx_header_parser class pulses do not match frames");

endmodule

// File: verilog/stream_fifo.sv
// push while full or pop while empty is a fault and is ignored by the buffer
`timescale 1ns/1ps
`include "dns_filter_params.svh"

module stream_fifo import dns_filter_pkg::*; #(
	parameter type payload_t = beat_t,
	parameter int  depth     = `QUEUE_DEPTH
) (
	input  logic     clk156,
	input  logic     rst,
	input  logic     push,
	input  payload_t push_data,
	output logic     full,
	input  logic     pop,
	output logic     empty,
	output payload_t pop_data
);

	localparam int AW = (depth > 1) ? $clog2(depth) : 1;
	localparam int CW = $clog2(depth + 1);

	payload_t      mem [depth];
	logic [AW-1:0] wr_ptr, rd_ptr;
	logic [CW-1:0] count;
	logic          wr_en, rd_en;

	assign full     = count == CW'(depth);
	assign empty    = count == '0;
	assign wr_en    = push && !full;
	assign rd_en    = pop && !empty;
	assign pop_data = mem[rd_ptr];  // fall-through head

	always_ff @(posedge clk156) begin
		if (wr_en)
			mem[wr_ptr] <= push_data;
	end

	always_ff @(posedge clk156) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (wr_en)
				wr_ptr <= (wr_ptr == AW'(depth - 1)) ? '0 : wr_ptr + 1'b1;
			if (rd_en)
				rd_ptr <= (rd_ptr == AW'(depth - 1)) ? '0 : rd_ptr + 1'b1;
			if (wr_en && !rd_en)
				count <= count + 1'b1;
			else if (rd_en && !wr_en)
				count <= count - 1'b1;
		end
	end

	a_no_overflow: assert property (@(posedge clk156) disable iff (rst) !(push && full))
		else $error("stream_fifo overflow, upstream pushed into a full queue");
	a_no_underflow: assert property (@(posedge clk156) disable iff (rst) !(pop && empty))
		else $error("stream_fifo underflow, downstream popped an empty queue");

endmodule

// File: verilog/tx_merge.sv
// output stage has no skid buffer so tx_ready reaches the sources combinationally
`timescale 1ns/1ps
`include "dns_filter_params.svh"

module tx_merge import dns_filter_pkg::*; (
	input  logic               clk156,
	input  logic               rst,
	input  logic               bypass_empty,
	input  beat_t              bypass_beat,
	output logic               bypass_pop,
	input  logic               pass_valid,
	input  beat_t              pass_beat,
	output logic               pass_ready,
	output logic               tx_valid,
	output logic [`DATA_W-1:0] tx_data,
	output logic [`KEEP_W-1:0] tx_keep,
	output logic               tx_last,
	input  logic               tx_ready
);

	logic  gnt_active;
	logic  gnt_sel;  // 1 is the pass path, also the round-robin pointer
	logic  grant_done, active_now, out_free, pick, sel, src_valid, take;
	beat_t src_beat;

	always_comb begin
		grant_done = tx_valid && tx_ready && tx_last;
		active_now = gnt_active && !grant_done;
		out_free   = !tx_valid || tx_ready;
		// prefer the path that did not have the last grant
		if (!gnt_sel)
			pick = pass_valid || bypass_empty;
		else
			pick = bypass_empty && pass_valid;
		sel        = active_now ? gnt_sel : pick;
		src_valid  = sel ? pass_valid : !bypass_empty;
		src_beat   = sel ? pass_beat : bypass_beat;
		take       = out_free && src_valid;
		bypass_pop = take && !sel;
		pass_ready = out_free && sel;
	end

	always_ff @(posedge clk156) begin
		if (take) begin
			tx_data <= src_beat.data;
			tx_keep <= src_beat.keep;
			tx_last <= src_beat.last;
		end
	end

	always_ff @(posedge clk156) begin
		if (rst) begin
			gnt_active <= 1'b0;
			gnt_sel    <= 1'b0;
			tx_valid   <= 1'b0;
		end else begin
			if (take && !active_now) begin
				gnt_active <= 1'b1;
				gnt_sel    <= sel;
			end else if (grant_done)
				gnt_active <= 1'b0;  // tlast left on transmit
			if (out_free)
				tx_valid <= take;
		end
	end

endmodule

// File: verilog/verdict_gate.sv
// a frame only starts once its verdict is queued and the verdict stays at the head until tlast
`timescale 1ns/1ps

module verdict_gate import dns_filter_pkg::*; (
	input  logic     clk156,
	input  logic     rst,
	input  logic     hold_empty,
	input  beat_t    hold_beat,
	output logic     hold_pop,
	input  logic     verdict_empty,
	input  verdict_t verdict,
	output logic     verdict_pop,
	output logic     pass_valid,
	output beat_t    pass_beat,
	input  logic     pass_ready
);

	logic in_frame;
	logic drop_frame;
	logic beat_done;

	// drop frames drain one beat per cycle without waiting on transmit
	assign pass_valid  = in_frame && !drop_frame && !hold_empty;
	assign pass_beat   = hold_beat;
	assign beat_done   = in_frame && !hold_empty && (drop_frame || pass_ready);
	assign hold_pop    = beat_done;
	assign verdict_pop = beat_done && hold_beat.last;

	always_ff @(posedge clk156) begin
		if (rst) begin
			in_frame   <= 1'b0;
			drop_frame <= 1'b0;
		end else if (!in_frame) begin
			if (!hold_empty && !verdict_empty) begin
				in_frame   <= 1'b1;
				drop_frame <= verdict.drop;
			end
		end else if (verdict_pop)
			in_frame <= 1'b0;
	end

endmodule
